// File: Bender.yml
package:
  name: cp0

sources:
  - files:
      - design/cp0_pkg.sv
      - design/exc_pkg.sv
      - design/cp0_bus_if.sv
      - design/exc_if.sv
      - design/cp0_timer.sv
      - design/cp0_state_regs.sv
      - design/cp0_exc_ctrl.sv
      - design/cp0_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/cp0_tb.sv

// File: design/cp0_bus_if.sv
`timescale 1ns/1ps

interface cp0_bus_if import cp0_pkg::*; ();

	logic      we;
	cp0_addr_t waddr;
	cp0_addr_t raddr;
	word_t     wdata;
	word_t     rdata; // combinational from raddr

	modport timer_mp (
		input we,
		input waddr,
		input wdata
	);

	modport regs_mp (
		input  we,
		input  waddr,
		input  raddr,
		input  wdata,
		output rdata
	);

endinterface

// File: design/cp0_exc_ctrl.sv
`timescale 1ns/1ps

module cp0_exc_ctrl import cp0_pkg::*, exc_pkg::*; (
	input  exc_type_t  excepttype_i,
	input  word_t      current_inst_addr_i,
	input  logic       is_in_delay_slot_i,
	input  logic       exl_i,
	input  word_t      epc_i,
	exc_if.ctrl_mp     exc,
	output logic       flush_o,
	output word_t      new_pc_o
);

	exc_kind_t kind;
	exccode_t  exccode;
	logic      take;
	logic      record;

	always_comb begin
		kind    = KIND_NONE;
		exccode = EXCCODE_INT;
		case (excepttype_i)
			EXT_INT: begin
				kind    = KIND_INT;
				exccode = EXCCODE_INT;
			end
			EXT_SYS: begin
				kind    = KIND_SYS;
				exccode = EXCCODE_SYS;
			end
			EXT_RI: begin
				kind    = KIND_RI;
				exccode = EXCCODE_RI;
			end
			EXT_OV: begin
				kind    = KIND_OV;
				exccode = EXCCODE_OV;
			end
			EXT_TR: begin
				kind    = KIND_TR;
				exccode = EXCCODE_TR;
			end
			EXT_ERET: begin
				kind = KIND_ERET; // exccode untouched
			end
			default: begin
			end
		endcase
	end

	assign take = (kind != KIND_NONE);

	// nested exceptions keep the first epc while interrupts always overwrite
	assign record = (kind == KIND_INT) ||
		(take && (kind != KIND_ERET) && !exl_i);

	assign exc.take    = take;
	assign exc.kind    = kind;
	assign exc.exccode = exccode;
	assign exc.record  = record;
	assign exc.bd      = is_in_delay_slot_i;
	assign exc.epc_val = is_in_delay_slot_i ? (current_inst_addr_i - 32'd4)
		: current_inst_addr_i; // point back at the branch

	assign flush_o = take;

	always_comb begin
		case (kind)
			KIND_NONE: begin
				new_pc_o = '0;
			end
			KIND_ERET: begin
				new_pc_o = epc_i;
			end
			default: begin
				new_pc_o = EXC_VECTOR;
			end
		endcase
	end

	always_comb begin
		a_flush_kind: assert final (!flush_o ||
			(excepttype_i inside {EXT_INT, EXT_SYS, EXT_RI, EXT_OV, EXT_TR, EXT_ERET}))
			else $error("flush without a recognized exception type");
	end

endmodule

// File: design/cp0_pkg.sv
package cp0_pkg;

	// basic widths
	typedef logic [31:0] word_t;
	typedef logic [4:0]  cp0_addr_t;
	typedef logic [5:0]  int_vec_t;

	// cp0 register numbers, sel 0
	localparam cp0_addr_t CP0_COUNT   = 5'd9;
	localparam cp0_addr_t CP0_COMPARE = 5'd11;
	localparam cp0_addr_t CP0_STATUS  = 5'd12;
	localparam cp0_addr_t CP0_CAUSE   = 5'd13;
	localparam cp0_addr_t CP0_EPC     = 5'd14;
	localparam cp0_addr_t CP0_PRID    = 5'd15;
	localparam cp0_addr_t CP0_CONFIG  = 5'd16;

	// reset values
	localparam word_t STATUS_RST = 32'h1000_0000; // cu0 only
	localparam word_t CONFIG_RST = 32'h0000_8000; // be, big-endian
	localparam word_t PRID_RST   = 32'h004c_0000; // company id 0x4c

	// status fields
	localparam int STATUS_EXL = 1;

	// cause fields
	localparam int CAUSE_BD         = 31;
	localparam int CAUSE_IP_HW_HI   = 15;
	localparam int CAUSE_IP_HW_LO   = 10;
	localparam int CAUSE_EXCCODE_HI = 6;
	localparam int CAUSE_EXCCODE_LO = 2;

	// software may only touch ip1..ip0 (9..8), iv and wp (23..22)
	localparam word_t CAUSE_SW_MASK = 32'h00c0_0300;

endpackage

// File: design/cp0_state_regs.sv
`timescale 1ns/1ps

module cp0_state_regs import cp0_pkg::*, exc_pkg::*; (
	input  logic       clk,
	input  logic       rst_i,
	cp0_bus_if.regs_mp bus,
	exc_if.regs_mp     exc,
	input  int_vec_t   int_i,
	input  word_t      count_i,
	input  word_t      compare_i,
	output word_t      status_o,
	output word_t      cause_o,
	output word_t      epc_o,
	output logic       exl_o
);

	logic status_we;
	logic cause_we;
	logic epc_we;
	logic exc_enter; // any taken exception other than eret
	logic exc_ret;

	assign status_we = bus.we && (bus.waddr == CP0_STATUS);
	assign cause_we  = bus.we && (bus.waddr == CP0_CAUSE);
	assign epc_we    = bus.we && (bus.waddr == CP0_EPC);

	assign exc_enter = exc.take && (exc.kind != KIND_ERET);
	assign exc_ret   = exc.take && (exc.kind == KIND_ERET);

	assign exl_o = status_o[STATUS_EXL];

	// later assignments win, so the exception overrides a write to the same field
	always_ff @(posedge clk) begin
		if (rst_i) begin
			status_o <= STATUS_RST;
		end else begin
			if (status_we) begin
				status_o <= bus.wdata;
			end
			if (exc_enter) begin
				status_o[STATUS_EXL] <= 1'b1;
			end else if (exc_ret) begin
				status_o[STATUS_EXL] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			cause_o <= '0;
		end else begin
			if (cause_we) begin
				cause_o <= (cause_o & ~CAUSE_SW_MASK) | (bus.wdata & CAUSE_SW_MASK);
			end
			cause_o[CAUSE_IP_HW_HI:CAUSE_IP_HW_LO] <= int_i; // hw lines, one cycle late
			if (exc_enter) begin
				cause_o[CAUSE_EXCCODE_HI:CAUSE_EXCCODE_LO] <= exc.exccode;
			end
			if (exc.take && exc.record) begin
				cause_o[CAUSE_BD] <= exc.bd;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			epc_o <= '0;
		end else begin
			if (epc_we) begin
				epc_o <= bus.wdata;
			end
			if (exc.take && exc.record) begin
				epc_o <= exc.epc_val;
			end
		end
	end

	// read port, prid and config are fixed
	always_comb begin
		case (bus.raddr)
			CP0_COUNT: begin
				bus.rdata = count_i;
			end
			CP0_COMPARE: begin
				bus.rdata = compare_i;
			end
			CP0_STATUS: begin
				bus.rdata = status_o;
			end
			CP0_CAUSE: begin
				bus.rdata = cause_o;
			end
			CP0_EPC: begin
				bus.rdata = epc_o;
			end
			CP0_PRID: begin
				bus.rdata = PRID_RST;
			end
			CP0_CONFIG: begin
				bus.rdata = CONFIG_RST;
			end
			default: begin
				bus.rdata = '0;
			end
		endcase
	end

	a_exl_after_exc: assert property (
		@(posedge clk) disable iff (rst_i)
		exc_enter |=> exl_o
	) else $error("exl not set after exception entry");

endmodule

// File: design/cp0_timer.sv
`timescale 1ns/1ps

module cp0_timer import cp0_pkg::*; (
	input  logic        clk,
	input  logic        rst_i,
	cp0_bus_if.timer_mp bus,
	output word_t       count_o,
	output word_t       compare_o,
	output logic        timer_int_o
);

	logic count_we;
	logic compare_we;
	logic match;

	assign count_we   = bus.we && (bus.waddr == CP0_COUNT);
	assign compare_we = bus.we && (bus.waddr == CP0_COMPARE);
	assign match      = (compare_o != '0) && (count_o == compare_o); // zero compare is off

	always_ff @(posedge clk) begin
		if (rst_i) begin
			count_o <= '0;
		end else if (count_we) begin
			count_o <= bus.wdata; // write replaces the increment
		end else begin
			count_o <= count_o + 32'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			compare_o <= '0;
		end else if (compare_we) begin
			compare_o <= bus.wdata;
		end
	end

	// sticky until software rewrites compare
	always_ff @(posedge clk) begin
		if (rst_i) begin
			timer_int_o <= 1'b0;
		end else if (compare_we) begin
			timer_int_o <= 1'b0;
		end else if (match) begin
			timer_int_o <= 1'b1;
		end
	end

	a_timer_int_hold: assert property (
		@(posedge clk) disable iff (rst_i)
		$fell(timer_int_o) |-> ($past(compare_we) || $past(rst_i))
	) else $error("timer interrupt dropped without compare write");

endmodule

// File: design/cp0_top.sv
`timescale 1ns/1ps

module cp0_top import cp0_pkg::*, exc_pkg::*; (
	input  logic      clk,
	input  logic      rst_i,
	input  logic      we_i,
	input  cp0_addr_t waddr_i,
	input  cp0_addr_t raddr_i,
	input  word_t     data_i,
	input  int_vec_t  int_i,
	input  exc_type_t excepttype_i,
	input  word_t     current_inst_addr_i,
	input  logic      is_in_delay_slot_i,
	output word_t     data_o,
	output word_t     status_o,
	output word_t     cause_o,
	output word_t     epc_o,
	output logic      timer_int_o,
	output logic      flush_o,
	output word_t     new_pc_o
);

	cp0_bus_if bus ();
	exc_if     exc ();

	word_t count;
	word_t compare;
	logic  exl;

	// mtc0/mfc0 port onto the bus
	assign bus.we    = we_i;
	assign bus.waddr = waddr_i;
	assign bus.raddr = raddr_i;
	assign bus.wdata = data_i;
	assign data_o    = bus.rdata;

	cp0_timer cp0_timer_inst (
		.clk         (clk),
		.rst_i       (rst_i),
		.bus         (bus.timer_mp),
		.count_o     (count),
		.compare_o   (compare),
		.timer_int_o (timer_int_o)
	);

	cp0_state_regs cp0_state_regs_inst (
		.clk       (clk),
		.rst_i     (rst_i),
		.bus       (bus.regs_mp),
		.exc       (exc.regs_mp),
		.int_i     (int_i),
		.count_i   (count),
		.compare_i (compare),
		.status_o  (status_o),
		.cause_o   (cause_o),
		.epc_o     (epc_o),
		.exl_o     (exl)
	);

	cp0_exc_ctrl cp0_exc_ctrl_inst (
		.excepttype_i        (excepttype_i),
		.current_inst_addr_i (current_inst_addr_i),
		.is_in_delay_slot_i  (is_in_delay_slot_i),
		.exl_i               (exl),
		.epc_i               (epc_o),
		.exc                 (exc.ctrl_mp),
		.flush_o             (flush_o),
		.new_pc_o            (new_pc_o)
	);

endmodule

// File: design/exc_if.sv
`timescale 1ns/1ps

interface exc_if import cp0_pkg::*, exc_pkg::*; ();

	logic      take;    // exception this cycle
	exc_kind_t kind;
	exccode_t  exccode;
	logic      record;  // load epc and bd
	logic      bd;
	word_t     epc_val;

	modport ctrl_mp (
		output take,
		output kind,
		output exccode,
		output record,
		output bd,
		output epc_val
	);

	modport regs_mp (
		input take,
		input kind,
		input exccode,
		input record,
		input bd,
		input epc_val
	);

endinterface

// File: design/exc_pkg.sv
package exc_pkg;

	import cp0_pkg::*;

	// type word coming down from the mem stage
	typedef logic [31:0] exc_type_t;

	localparam exc_type_t EXT_INT  = 32'h0000_0001;
	localparam exc_type_t EXT_SYS  = 32'h0000_0008;
	localparam exc_type_t EXT_RI   = 32'h0000_000a;
	localparam exc_type_t EXT_OV   = 32'h0000_000c;
	localparam exc_type_t EXT_TR   = 32'h0000_000d;
	localparam exc_type_t EXT_ERET = 32'h0000_000e;

	typedef enum logic [2:0] {
		KIND_NONE,
		KIND_INT,
		KIND_SYS,
		KIND_RI,
		KIND_OV,
		KIND_TR,
		KIND_ERET
	} exc_kind_t;

	// cause.exccode values
	typedef logic [4:0] exccode_t;

	localparam exccode_t EXCCODE_INT = 5'd0;
	localparam exccode_t EXCCODE_SYS = 5'd8;
	localparam exccode_t EXCCODE_RI  = 5'd10;
	localparam exccode_t EXCCODE_OV  = 5'd12;
	localparam exccode_t EXCCODE_TR  = 5'd13;

	localparam word_t EXC_VECTOR = 32'h0000_0020; // single entry point

endpackage

// File: dv/cp0_model.svh
`ifndef CP0_MODEL_SVH
`define CP0_MODEL_SVH

// expected register contents after the latest rising edge
word_t exp_count;
word_t exp_compare;
logic  exp_timer_int;
word_t exp_status;
word_t exp_cause;
word_t exp_epc;

function automatic void clear_expected();
	exp_count     = '0;
	exp_compare   = '0;
	exp_timer_int = 1'b0;
	exp_status    = 32'h1000_0000; // cu0
	exp_cause     = '0;
	exp_epc       = '0;
endfunction

function automatic logic is_exception(input exc_type_t t);
	case (t)
		32'h1, 32'h8, 32'ha, 32'hc, 32'hd, 32'he: return 1'b1;
		default: return 1'b0;
	endcase
endfunction

function automatic exccode_t expected_exccode(input exc_type_t t);
	case (t)
		32'h8: return 5'd8;
		32'ha: return 5'd10;
		32'hc: return 5'd12;
		32'hd: return 5'd13;
		default: return 5'd0; // interrupt
	endcase
endfunction

function automatic word_t expected_new_pc(input exc_type_t t);
	return (t == 32'he) ? exp_epc : 32'h0000_0020;
endfunction

function automatic word_t expected_read(input cp0_addr_t a);
	case (a)
		5'd9:  return exp_count;
		5'd11: return exp_compare;
		5'd12: return exp_status;
		5'd13: return exp_cause;
		5'd14: return exp_epc;
		5'd15: return 32'h004c_0000;
		5'd16: return 32'h0000_8000;
		default: return '0;
	endcase
endfunction

// one rising edge, every rule works on the values before the edge
task automatic advance_model(input logic we, input cp0_addr_t wa, input word_t wd,
	input int_vec_t irq, input exc_type_t t, input word_t pc, input logic ds);
	logic take;
	logic enter;
	logic record;
	take   = is_exception(t);
	enter  = take && (t != 32'he);
	record = (t == 32'h1) || (enter && !exp_status[1]);
	if (we && wa == 5'd11) exp_timer_int = 1'b0;
	else if (exp_compare != '0 && exp_count == exp_compare) exp_timer_int = 1'b1;
	exp_count = (we && wa == 5'd9) ? wd : exp_count + 32'd1;
	if (we && wa == 5'd11) exp_compare = wd;
	if (we && wa == 5'd12) exp_status = wd;
	if (enter) exp_status[1] = 1'b1;
	else if (take) exp_status[1] = 1'b0; // eret
	if (we && wa == 5'd13) exp_cause = (exp_cause & ~32'h00c0_0300) | (wd & 32'h00c0_0300);
	exp_cause[15:10] = irq;
	if (enter) exp_cause[6:2] = expected_exccode(t);
	if (record) exp_cause[31] = ds;
	if (we && wa == 5'd14) exp_epc = wd;
	if (record) exp_epc = ds ? (pc - 32'd4) : pc;
endtask

`endif

// File: dv/cp0_tb.sv
`timescale 1ns/1ps

module cp0_tb import cp0_pkg::*, exc_pkg::*; ();

	logic      clk;
	logic      rst_i;
	logic      we_i;
	cp0_addr_t waddr_i;
	cp0_addr_t raddr_i;
	word_t     data_i;
	int_vec_t  int_i;
	exc_type_t excepttype_i;
	word_t     current_inst_addr_i;
	logic      is_in_delay_slot_i;
	word_t     data_o;
	word_t     status_o;
	word_t     cause_o;
	word_t     epc_o;
	logic      timer_int_o;
	logic      flush_o;
	word_t     new_pc_o;
	integer    seed;

	`include "cp0_model.svh"

	cp0_top cp0_top_inst (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic fail_run();
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_value(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
			fail_run();
		end
	endtask

	task automatic apply_inputs(input logic we, input cp0_addr_t wa, input cp0_addr_t ra,
		input word_t wd, input exc_type_t t, input word_t pc, input logic ds);
		we_i                = we;
		waddr_i             = wa;
		raddr_i             = ra;
		data_i              = wd;
		int_i               = $random(seed); // hw lines always random
		excepttype_i        = t;
		current_inst_addr_i = pc;
		is_in_delay_slot_i  = ds;
	endtask

	// called right after a falling edge with the inputs already applied
	task automatic step_and_check();
		#10;
		check_value("data_o", data_o, expected_read(raddr_i));
		check_value("status_o", status_o, exp_status);
		check_value("cause_o", cause_o, exp_cause);
		check_value("epc_o", epc_o, exp_epc);
		check_value("timer_int_o", timer_int_o, exp_timer_int);
		check_value("flush_o", flush_o, is_exception(excepttype_i));
		if (is_exception(excepttype_i))
			check_value("new_pc_o", new_pc_o, expected_new_pc(excepttype_i));
		@(posedge clk);
		advance_model(we_i, waddr_i, data_i, int_i, excepttype_i,
			current_inst_addr_i, is_in_delay_slot_i);
		@(negedge clk);
	endtask

	task automatic wait_timer_int(input int max_cycles);
		int n;
		n = 0;
		while (!timer_int_o && n < max_cycles) begin
			apply_inputs(1'b0, '0, CP0_COUNT, '0, '0, '0, 1'b0);
			step_and_check();
			n++;
		end
		if (!timer_int_o) begin
			$display("timer interrupt did not rise within %0d cycles", max_cycles);
			fail_run();
		end
	endtask

	function automatic cp0_addr_t pick_reg();
		logic [2:0] sel;
		sel = $random(seed);
		case (sel)
			3'd0: return CP0_COUNT;
			3'd1: return CP0_COMPARE;
			3'd2: return CP0_STATUS;
			3'd3: return CP0_CAUSE;
			3'd4: return CP0_EPC;
			3'd5: return CP0_PRID;
			3'd6: return CP0_CONFIG;
			default: return cp0_addr_t'($random(seed)); // mostly unmapped
		endcase
	endfunction

	function automatic exc_type_t pick_exc();
		logic [3:0] sel;
		sel = $random(seed);
		case (sel)
			4'd0: return EXT_INT;
			4'd1: return EXT_SYS;
			4'd2: return EXT_RI;
			4'd3: return EXT_OV;
			4'd4: return EXT_TR;
			4'd5: return EXT_ERET;
			4'd6: return $random(seed); // junk word
			default: return '0;
		endcase
	endfunction

	initial begin
		seed  = 32'h0185_990d;
		rst_i = 1'b1;
		apply_inputs(1'b0, '0, '0, '0, '0, '0, 1'b0);
		repeat (2) @(posedge clk);
		clear_expected();
		@(negedge clk);
		rst_i = 1'b0;

		for (int a = 0; a < 32; a++) begin // reset values and unmapped reads
			apply_inputs(1'b0, '0, cp0_addr_t'(a), '0, '0, '0, 1'b0);
			step_and_check();
		end

		repeat (200) begin // software writes only
			apply_inputs($random(seed), pick_reg(), pick_reg(), $random(seed), '0, '0, 1'b0);
			step_and_check();
		end

		apply_inputs(1'b1, CP0_COMPARE, CP0_COUNT, exp_count + 32'd6, '0, '0, 1'b0);
		step_and_check();
		wait_timer_int(20);
		repeat (3) begin
			apply_inputs(1'b0, '0, CP0_COMPARE, '0, '0, '0, 1'b0);
			step_and_check();
		end
		apply_inputs(1'b1, CP0_COMPARE, CP0_COUNT, exp_count - 32'd1, '0, '0, 1'b0);
		step_and_check();

		// zero compare while count wraps through zero
		apply_inputs(1'b1, CP0_COMPARE, CP0_COMPARE, '0, '0, '0, 1'b0);
		step_and_check();
		apply_inputs(1'b1, CP0_COUNT, CP0_COUNT, 32'hffff_fffc, '0, '0, 1'b0);
		step_and_check();
		repeat (10) begin
			apply_inputs(1'b0, '0, CP0_COUNT, '0, '0, '0, 1'b0);
			step_and_check();
			check_value("timer_int_o", timer_int_o, 1'b0);
		end

		repeat (400) begin
			apply_inputs(($random(seed) & 3) == 0, pick_reg(), pick_reg(), $random(seed),
				pick_exc(), $random(seed), $random(seed));
			step_and_check();
		end

		apply_inputs(1'b1, CP0_STATUS, CP0_STATUS, '0, EXT_SYS, 32'h0000_1000, 1'b0);
		step_and_check();
		check_value("status_o.exl", status_o[STATUS_EXL], 1'b1);
		apply_inputs(1'b1, CP0_EPC, CP0_EPC, 32'h0000_4000, EXT_ERET, '0, 1'b0);
		step_and_check();
		check_value("status_o.exl", status_o[STATUS_EXL], 1'b0);
		apply_inputs(1'b1, CP0_EPC, CP0_EPC, 32'h0000_4000, EXT_INT, 32'h0000_2000, 1'b1);
		step_and_check();
		check_value("epc_o", epc_o, 32'h0000_1ffc); // delay slot points at the branch

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// File: sim.f
+incdir+dv
design/cp0_pkg.sv
design/exc_pkg.sv
design/cp0_bus_if.sv
design/exc_if.sv
design/cp0_timer.sv
design/cp0_state_regs.sv
design/cp0_exc_ctrl.sv
design/cp0_top.sv
dv/cp0_tb.sv
